//--- all.f
+incdir+src
src/bus_pkg.sv
src/trace_pkg.sv
src/bus_tap.sv
src/trace_filter.sv
src/trace_buffer.sv
src/mem_slave.sv
src/tap_top.sv
tb/tb_tap_top.sv

//--- tb/tb_tap_top.sv
`include "bustap_config.svh"

module tb_tap_top;

    localparam int num_xfers    = 300;
    localparam int phase1_xfers = 200;                  // Rest run with trace_ready low
    localparam int cycle_limit  = num_xfers * 8 + 200;
    localparam int depth        = `BT_TRACE_DEPTH;

    logic                  gls_clk;
    logic                  rst_n;
    logic                  chipselect;
    bus_pkg::bus_req_t     host_req;
    bus_pkg::bus_rsp_t     host_rsp;
    bus_pkg::addr_t        win_base;
    bus_pkg::addr_t        win_mask;
    logic                  trace_valid;
    logic                  trace_ready;
    trace_pkg::trace_rec_t trace_rec;
    trace_pkg::seq_t       drop_count;

    bus_pkg::data_t        mem_model [`BT_MEM_WORDS];
    trace_pkg::trace_rec_t exp_q [$];
    int                    seq_model    = 0;
    int                    fifo_fill    = 0;
    int                    lost_model   = 0;
    int                    mismatch_cnt = 0;
    int                    other_cnt    = 0;
    int                    rec_cnt      = 0;
    int                    cycles       = 0;
    int                    ready_mode   = 0;            // 0 random, 1 high, 2 low
    bit                    stalled      = 1'b0;
    bit                    have_last    = 1'b0;
    trace_pkg::seq_t       last_seq;

    tap_top dut_i (
        .gls_clk     (gls_clk),
        .rst_n       (rst_n),
        .chipselect  (chipselect),
        .host_req    (host_req),
        .host_rsp    (host_rsp),
        .win_base    (win_base),
        .win_mask    (win_mask),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready),
        .trace_rec   (trace_rec),
        .drop_count  (drop_count)
    );

    initial begin
        gls_clk = 1'b0;
        forever #10 gls_clk = ~gls_clk;
    end

    task automatic note_mismatch(input string sig, input logic [63:0] expv,
                                 input logic [63:0] gotv);
        $display("FAILED at %0t: %s expected %h, got %h", $time, sig, expv, gotv);
        mismatch_cnt++;
    endtask

    task automatic report_failure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        other_cnt++;
    endtask

    task automatic print_summary();
        $display("Summary: %0d value mismatches, %0d other errors, %0d records checked, %0d lost",
                 mismatch_cnt, other_cnt, rec_cnt, lost_model);
    endtask

    // Every bit under the mask has to agree with the base
    function automatic bit addr_in_window(input bus_pkg::addr_t addr);
        for (int i = 0; i < `BT_ADDR_W; i++) begin
            if (win_mask[i] && addr[i] != win_base[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // FIFO with ready held low keeps the first depth records
    task automatic queue_record(input trace_pkg::trace_rec_t rec);
        if (!stalled) begin
            exp_q.push_back(rec);
        end else if (fifo_fill < depth) begin
            exp_q.push_back(rec);
            fifo_fill++;
        end else begin
            lost_model++;
        end
    endtask

    task automatic run_transfer();
        int                    idle;
        int                    waits;
        bit                    is_wr;
        logic [7:0]            idx;
        bus_pkg::addr_t        addr;
        bus_pkg::data_t        wdata;
        bus_pkg::be_t          be;
        trace_pkg::trace_rec_t rec;
        idle  = ($urandom_range(0, 2) == 0) ? $urandom_range(1, 3) : 0;
        is_wr = $urandom_range(0, 1);
        idx   = $urandom_range(0, 255);
        addr  = bus_pkg::addr_t'({idx, 2'b00});
        wdata = $urandom;
        be    = $urandom_range(0, 15);
        repeat (idle) begin
            @(posedge gls_clk);
            chipselect       <= 1'b0;             // Random strobes that chipselect masks
            host_req.read    <= $urandom_range(0, 1);
            host_req.write   <= $urandom_range(0, 1);
            host_req.address <= $urandom;
        end
        @(posedge gls_clk);
        chipselect          <= 1'b1;
        host_req.read       <= !is_wr;
        host_req.write      <= is_wr;
        host_req.address    <= addr;
        host_req.writedata  <= wdata;
        host_req.byteenable <= be;
        waits = 0;
        @(negedge gls_clk);
        while (host_rsp.waitrequest) begin
            waits++;
            @(negedge gls_clk);
        end
        if (waits > 3) begin
            report_failure("a transfer saw more than 3 wait cycles");
        end
        rec.seq        = trace_pkg::seq_t'(seq_model);
        rec.address    = addr;
        rec.byteenable = be;
        if (is_wr) begin
            rec.kind = trace_pkg::acc_write;
            rec.data = wdata;
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    mem_model[idx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end else begin
            rec.kind = trace_pkg::acc_read;
            rec.data = mem_model[idx];
            if (host_rsp.readdata !== mem_model[idx]) begin
                note_mismatch("host_rsp.readdata", mem_model[idx], host_rsp.readdata);
            end
        end
        seq_model++;
        if (addr_in_window(addr)) begin
            queue_record(rec);
        end
    endtask

    task automatic go_idle();
        @(posedge gls_clk);
        chipselect     <= 1'b0;
        host_req.read  <= 1'b0;
        host_req.write <= 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0 || trace_valid) begin
            @(negedge gls_clk);
        end
    endtask

    task automatic check_popped();
        trace_pkg::trace_rec_t exp_rec;
        if (exp_q.size() == 0) begin
            report_failure("trace record delivered while none was expected");
        end else begin
            exp_rec = exp_q.pop_front();
            rec_cnt++;
            if (trace_rec.kind !== exp_rec.kind) begin
                note_mismatch("trace_rec.kind", exp_rec.kind, trace_rec.kind);
            end
            if (trace_rec.seq !== exp_rec.seq) begin
                note_mismatch("trace_rec.seq", exp_rec.seq, trace_rec.seq);
            end
            if (trace_rec.address !== exp_rec.address) begin
                note_mismatch("trace_rec.address", exp_rec.address, trace_rec.address);
            end
            if (trace_rec.data !== exp_rec.data) begin
                note_mismatch("trace_rec.data", exp_rec.data, trace_rec.data);
            end
            if (trace_rec.byteenable !== exp_rec.byteenable) begin
                note_mismatch("trace_rec.byteenable", exp_rec.byteenable, trace_rec.byteenable);
            end
            if (have_last && trace_rec.seq <= last_seq) begin
                report_failure("trace sequence numbers did not increase");
            end
            have_last = 1'b1;
            last_seq  = trace_rec.seq;
        end
    endtask

    // Readout monitor sampling before the popping edge
    initial begin
        forever begin
            @(negedge gls_clk);
            if (rst_n && trace_valid && trace_ready) begin
                check_popped();
            end
        end
    end

    initial begin
        forever begin
            @(posedge gls_clk);
            case (ready_mode)
                0:       trace_ready <= ($urandom_range(0, 3) != 0);
                1:       trace_ready <= 1'b1;
                default: trace_ready <= 1'b0;
            endcase
        end
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge gls_clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        print_summary();
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        void'($urandom(84));
        for (int i = 0; i < `BT_MEM_WORDS; i++) begin
            mem_model[i] = '0;
        end
        rst_n       <= 1'b0;
        chipselect  <= 1'b0;
        host_req    <= '0;
        win_base    <= '0;
        win_mask    <= 32'h0000_0200;         // Address bit 9 selects half the memory
        trace_ready <= 1'b0;
        repeat (5) @(posedge gls_clk);
        rst_n <= 1'b1;
        @(negedge gls_clk);
        if (trace_valid !== 1'b0) begin
            note_mismatch("trace_valid", 1'b0, trace_valid);
        end
        if (drop_count !== '0) begin
            note_mismatch("drop_count", 0, drop_count);
        end

        repeat (phase1_xfers) run_transfer();
        go_idle();
        @(negedge gls_clk);
        ready_mode = 1;
        drain();
        if (drop_count !== '0) begin
            note_mismatch("drop_count", 0, drop_count);
        end

        // Stalled readout from an empty FIFO
        stalled    = 1'b1;
        ready_mode = 2;
        repeat (num_xfers - phase1_xfers) run_transfer();
        go_idle();
        repeat (4) @(negedge gls_clk);        // Let the last capture reach the FIFO
        ready_mode = 1;
        drain();
        repeat (4) @(negedge gls_clk);
        if (fifo_fill < depth) begin
            report_failure("trace FIFO never filled while trace_ready was low");
        end
        if (drop_count !== trace_pkg::seq_t'(lost_model)) begin
            note_mismatch("drop_count", lost_model, drop_count);
        end

        print_summary();
        if (mismatch_cnt + other_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src/tap_top.sv
module tap_top (
    input  logic                  gls_clk,
    input  logic                  rst_n,
    input  logic                  chipselect,
    input  bus_pkg::bus_req_t     host_req,
    output bus_pkg::bus_rsp_t     host_rsp,
    input  bus_pkg::addr_t        win_base,
    input  bus_pkg::addr_t        win_mask,
    output logic                  trace_valid,
    input  logic                  trace_ready,
    output trace_pkg::trace_rec_t trace_rec,
    output trace_pkg::seq_t       drop_count
);

    bus_pkg::bus_req_t     slv_req;
    bus_pkg::bus_rsp_t     slv_rsp;
    logic                  cap_valid;
    trace_pkg::trace_rec_t cap_rec;
    logic                  push;
    trace_pkg::trace_rec_t push_rec;

    bus_tap tap_i (
        .gls_clk    (gls_clk),
        .rst_n      (rst_n),
        .chipselect (chipselect),
        .host_req   (host_req),
        .host_rsp   (host_rsp),
        .slv_req    (slv_req),
        .slv_rsp    (slv_rsp),
        .cap_valid  (cap_valid),
        .cap_rec    (cap_rec)
    );

    trace_filter filter_i (
        .gls_clk   (gls_clk),
        .rst_n     (rst_n),
        .cap_valid (cap_valid),
        .cap_rec   (cap_rec),
        .win_base  (win_base),
        .win_mask  (win_mask),
        .push      (push),
        .push_rec  (push_rec)
    );

    trace_buffer buffer_i (
        .gls_clk     (gls_clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_rec    (push_rec),
        .trace_valid (trace_valid),
        .trace_ready (trace_ready),
        .trace_rec   (trace_rec),
        .drop_count  (drop_count)
    );

    mem_slave mem_i (
        .gls_clk (gls_clk),
        .rst_n   (rst_n),
        .req     (slv_req),
        .rsp     (slv_rsp)
    );

endmodule

//--- src/mem_slave.sv
`include "bustap_config.svh"

module mem_slave (
    input  logic              gls_clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t req,
    output bus_pkg::bus_rsp_t rsp
);

    localparam int idx_w = $clog2(`BT_MEM_WORDS);
    localparam int lanes = `BT_DATA_W / 8;

    bus_pkg::data_t   mem [`BT_MEM_WORDS];
    logic [idx_w-1:0] word_idx;
    logic [7:0]       lfsr;
    logic [1:0]       wait_new;
    logic [1:0]       wait_cnt;
    logic             busy;
    logic             active;
    logic             done;

    assign word_idx = req.address[idx_w+1:2];   // Upper address bits ignored
    assign active   = req.read | req.write;
    assign wait_new = lfsr[1:0];                // 0 to 3 wait cycles

    always_comb begin
        rsp.waitrequest = active & (busy ? (wait_cnt != '0) : (wait_new != '0));
        rsp.readdata    = mem[word_idx];
    end

    assign done = active & ~rsp.waitrequest;

    // Wait-state sequencing
    always_ff @(posedge gls_clk) begin
        if (!rst_n) begin
            lfsr     <= 8'hA5;      // Any nonzero seed
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (done) begin
                lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
                busy <= 1'b0;
            end else if (active && !busy) begin
                busy     <= 1'b1;
                wait_cnt <= wait_new - 1'b1;
            end else if (busy) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    // Storage, byte lanes written on completion
    always_ff @(posedge gls_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `BT_MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (done && req.write) begin
            for (int b = 0; b < lanes; b++) begin
                if (req.byteenable[b]) begin
                    mem[word_idx][b*8 +: 8] <= req.writedata[b*8 +: 8];
                end
            end
        end
    end

endmodule

//--- src/trace_buffer.sv
`include "bustap_config.svh"

module trace_buffer (
    input  logic                  gls_clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  trace_pkg::trace_rec_t push_rec,
    output logic                  trace_valid,
    input  logic                  trace_ready,
    output trace_pkg::trace_rec_t trace_rec,
    output trace_pkg::seq_t       drop_count
);

    localparam int depth = `BT_TRACE_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    trace_pkg::trace_rec_t store [depth];
    logic [ptr_w-1:0]      wr_ptr;
    logic [ptr_w-1:0]      rd_ptr;
    logic [ptr_w-1:0]      wr_nxt;
    logic [ptr_w-1:0]      rd_nxt;
    trace_pkg::buf_state_t state;
    trace_pkg::buf_state_t state_nxt;
    logic                  rd_en;
    logic                  wr_en;
    logic                  drop;

    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign trace_valid = (state != trace_pkg::buf_empty);
    assign trace_rec   = store[rd_ptr];     // Head straight from storage

    assign rd_en = trace_valid & trace_ready;
    assign wr_en = push & ((state != trace_pkg::buf_full) | rd_en);  // Full but popping is ok
    assign drop  = push & ~wr_en;

    assign wr_nxt = ptr_inc(wr_ptr);
    assign rd_nxt = ptr_inc(rd_ptr);

    always_comb begin
        state_nxt = state;
        case (state)
            trace_pkg::buf_empty: begin
                if (wr_en) begin
                    state_nxt = (wr_nxt == rd_ptr) ? trace_pkg::buf_full
                                                   : trace_pkg::buf_partial;
                end
            end
            trace_pkg::buf_partial: begin
                if (wr_en && !rd_en && wr_nxt == rd_ptr) begin
                    state_nxt = trace_pkg::buf_full;
                end else if (rd_en && !wr_en && rd_nxt == wr_ptr) begin
                    state_nxt = trace_pkg::buf_empty;
                end
            end
            trace_pkg::buf_full: begin
                if (rd_en && !wr_en) begin
                    state_nxt = trace_pkg::buf_partial;
                end
            end
            default: state_nxt = trace_pkg::buf_empty;
        endcase
    end

    always_ff @(posedge gls_clk) begin
        if (!rst_n) begin
            state      <= trace_pkg::buf_empty;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            drop_count <= '0;
        end else begin
            state <= state_nxt;
            if (wr_en) begin
                wr_ptr <= wr_nxt;
            end
            if (rd_en) begin
                rd_ptr <= rd_nxt;
            end
            if (drop && drop_count != '1) begin
                drop_count <= drop_count + 1'b1;    // Saturates
            end
        end
    end

    always_ff @(posedge gls_clk) begin
        if (wr_en) begin
            store[wr_ptr] <= push_rec;
        end
    end

endmodule

//--- src/trace_filter.sv
module trace_filter (
    input  logic                  gls_clk,
    input  logic                  rst_n,
    input  logic                  cap_valid,
    input  trace_pkg::trace_rec_t cap_rec,
    input  bus_pkg::addr_t        win_base,
    input  bus_pkg::addr_t        win_mask,
    output logic                  push,
    output trace_pkg::trace_rec_t push_rec
);

    bus_pkg::addr_t diff_bits;
    logic           in_window;
    logic           take;

    // Only bits selected by the mask have to agree with the base
    assign diff_bits = (cap_rec.address ^ win_base) & win_mask;
    assign in_window = (diff_bits == '0);
    assign take      = cap_valid & in_window;

    always_ff @(posedge gls_clk) begin
        if (!rst_n) begin
            push <= 1'b0;
        end else begin
            push <= take;               // Misses simply vanish
        end
    end

    always_ff @(posedge gls_clk) begin
        if (take) begin
            push_rec <= cap_rec;
        end
    end

endmodule

//--- src/bus_tap.sv
module bus_tap (
    input  logic                  gls_clk,
    input  logic                  rst_n,
    input  logic                  chipselect,
    input  bus_pkg::bus_req_t     host_req,
    output bus_pkg::bus_rsp_t     host_rsp,
    output bus_pkg::bus_req_t     slv_req,
    input  bus_pkg::bus_rsp_t     slv_rsp,
    output logic                  cap_valid,
    output trace_pkg::trace_rec_t cap_rec
);

    logic            xfer_done;
    logic            is_write;
    trace_pkg::seq_t seq_cnt;

    // Forward path, strobes qualified by chipselect
    always_comb begin
        slv_req       = host_req;
        slv_req.read  = host_req.read & chipselect;
        slv_req.write = host_req.write & chipselect;
    end

    assign host_rsp = slv_rsp;          // Wait states and read data untouched

    assign is_write  = slv_req.write;
    assign xfer_done = (slv_req.read | slv_req.write) & ~slv_rsp.waitrequest;

    // Capture strobe and running transfer count
    always_ff @(posedge gls_clk) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
            seq_cnt   <= '0;
        end else begin
            cap_valid <= xfer_done;
            if (xfer_done) begin
                seq_cnt <= seq_cnt + 1'b1;
            end
        end
    end

    // Record payload, loaded only on a completed transfer
    always_ff @(posedge gls_clk) begin
        if (xfer_done) begin
            cap_rec.seq        <= seq_cnt;      // Count before this transfer
            cap_rec.address    <= host_req.address;
            cap_rec.byteenable <= host_req.byteenable;
            if (is_write) begin
                cap_rec.kind <= trace_pkg::acc_write;
                cap_rec.data <= host_req.writedata;
            end else begin
                cap_rec.kind <= trace_pkg::acc_read;
                cap_rec.data <= slv_rsp.readdata;   // Valid in the done cycle
            end
        end
    end

endmodule

//--- src/trace_pkg.sv
`include "bustap_config.svh"

package trace_pkg;

    typedef enum logic {
        acc_read  = 1'b0,
        acc_write = 1'b1
    } access_t;

    typedef logic [`BT_SEQ_W-1:0] seq_t;

    // One captured bus transfer
    typedef struct packed {
        access_t        kind;
        seq_t           seq;        // Count of earlier completed transfers
        bus_pkg::addr_t address;
        bus_pkg::data_t data;       // Write data or returned read data
        bus_pkg::be_t   byteenable;
    } trace_rec_t;

    typedef enum logic [1:0] {
        buf_empty   = 2'd0,
        buf_partial = 2'd1,
        buf_full    = 2'd2
    } buf_state_t;

endpackage

//--- src/bus_pkg.sv
`include "bustap_config.svh"

package bus_pkg;

    typedef logic [`BT_ADDR_W-1:0]   addr_t;
    typedef logic [`BT_DATA_W-1:0]   data_t;
    typedef logic [`BT_DATA_W/8-1:0] be_t;

    // Master to slave, Avalon style
    typedef struct packed {
        logic  read;
        logic  write;
        addr_t address;
        data_t writedata;
        be_t   byteenable;
    } bus_req_t;

    // Slave to master
    typedef struct packed {
        logic  waitrequest;
        data_t readdata;            // Valid when waitrequest low
    } bus_rsp_t;

endpackage

//--- src/bustap_config.svh
`ifndef BUSTAP_CONFIG_SVH
`define BUSTAP_CONFIG_SVH

// Bus geometry
`define BT_ADDR_W 32
`define BT_DATA_W 32

// Memory slave depth in words, indexed by word address bits 9:2
`define BT_MEM_WORDS 256

// Trace FIFO entries
`define BT_TRACE_DEPTH 8

// Sequence number and drop counter width
`define BT_SEQ_W 16

`endif
